// File: sim.f
+incdir+design
design/rx_frame_pkg.sv
design/sig_field_parser.sv
design/fcs_checker.sv
design/frame_sequencer.sv
design/rx_frame_top.sv
test/tb_clock_gen.sv
test/rx_frame_checker.sv
test/tb_rx_frame.sv

// File: Bender.yml
package:
  name: rx_frame

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rx_frame_pkg.sv
      - design/sig_field_parser.sv
      - design/fcs_checker.sv
      - design/frame_sequencer.sv
      - design/rx_frame_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_clock_gen.sv
      - test/rx_frame_checker.sv
      - test/tb_rx_frame.sv

// File: test/tb_rx_frame.sv
`default_nettype none

`include "rx_frame_macros.svh"

module tb_rx_frame;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 500;
    localparam int DRIVE_DELAY    = 2;

    logic                      clock;
    logic                      equalizer_reset;
    logic                      frame_start;
    logic [7:0]                byte_data;
    logic                      byte_stb;
    logic                      demod_is_ongoing;
    rx_frame_pkg::pkt_header_t pkt_header;
    logic                      header_stb;
    logic [15:0]               byte_count;
    logic                      fcs_stb;
    logic                      fcs_ok;
    rx_frame_pkg::rx_status_e  status_code;

    integer                    seed;
    // payload followed by its four FCS bytes
    logic [7:0]                frame_mem [0:63];
    rx_frame_pkg::legacy_sig_t good_sig;

    tb_clock_gen u_clock (
        .clock           (clock),
        .equalizer_reset (equalizer_reset)
    );

    rx_frame_top DUT (
        .clock                     (clock),
        .equalizer_reset           (equalizer_reset),
        .frame_start_i             (frame_start),
        .byte_i                    (byte_data),
        .byte_stb_i                (byte_stb),
        .demod_is_ongoing_o        (demod_is_ongoing),
        .pkt_header_o              (pkt_header),
        .pkt_header_valid_strobe_o (header_stb),
        .byte_count_o              (byte_count),
        .fcs_out_strobe_o          (fcs_stb),
        .fcs_ok_o                  (fcs_ok),
        .status_code_o             (status_code)
    );

    rx_frame_checker u_check (
        .clock                     (clock),
        .equalizer_reset           (equalizer_reset),
        .demod_is_ongoing_i        (demod_is_ongoing),
        .pkt_header_i              (pkt_header),
        .pkt_header_valid_strobe_i (header_stb),
        .byte_count_i              (byte_count),
        .fcs_out_strobe_i          (fcs_stb),
        .fcs_ok_i                  (fcs_ok),
        .status_code_i             (status_code)
    );

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // standard reflected CRC-32 over the first n bytes of frame_mem
    function automatic logic [31:0] crc32_ref(input int n);
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++) begin
            crc = crc ^ {24'd0, frame_mem[i]};
            for (int b = 0; b < 8; b++) begin
                if (crc[0]) begin
                    crc = (crc >> 1) ^ 32'hEDB8_8320;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic rx_frame_pkg::legacy_sig_t make_sig(input logic [3:0]  rate,
                                                           input logic [11:0] len,
                                                           input logic        rsvd,
                                                           input logic [5:0]  tail,
                                                           input logic        bad_parity);
        rx_frame_pkg::legacy_sig_t s;
        s.rate   = rate;
        s.rsvd   = rsvd;
        s.len    = len;
        s.tail   = tail;
        s.parity = (^{len, rsvd, rate}) ^ bad_parity;
        return s;
    endfunction

    function automatic void predict(input  rx_frame_pkg::legacy_sig_t s,
                                    output rx_frame_pkg::rx_status_e  status,
                                    output rx_frame_pkg::pkt_header_t header,
                                    output logic                      fcs_good);
        int          n_payload;
        logic [31:0] sent_fcs;
        if (^s[17:0]) begin
            status = rx_frame_pkg::E_PARITY_FAIL;
        end else if (s.rsvd) begin
            status = rx_frame_pkg::E_WRONG_RSVD;
        end else if (s.tail != 6'd0) begin
            status = rx_frame_pkg::E_WRONG_TAIL;
        end else if (!s.rate[3]) begin
            status = rx_frame_pkg::E_UNSUPPORTED_RATE;
        end else begin
            status = rx_frame_pkg::E_OK;
        end
        header.valid = (status == rx_frame_pkg::E_OK);
        header.rate  = s.rate;
        header.len   = s.len;
        // last four bytes of the data phase carry the FCS, low byte first
        n_payload = int'(s.len) - 4;
        sent_fcs  = {frame_mem[n_payload + 3], frame_mem[n_payload + 2],
                     frame_mem[n_payload + 1], frame_mem[n_payload]};
        fcs_good  = (crc32_ref(n_payload) == sent_fcs);
    endfunction

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic build_payload(input int n_payload);
        logic [31:0] fcs;
        for (int i = 0; i < n_payload; i++) begin
            frame_mem[i] = 8'($random(seed));
        end
        fcs = crc32_ref(n_payload);
        for (int k = 0; k < 4; k++) begin
            frame_mem[n_payload + k] = fcs[8*k +: 8];
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        int gap;
        gap = $random(seed) & 32'd3;
        idle_cycles(gap);
        byte_data = value;
        byte_stb  = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        byte_stb  = 1'b0;
    endtask

    task automatic send_frame(input rx_frame_pkg::legacy_sig_t sig_field, input int n_data);
        frame_start = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        frame_start = 1'b0;
        for (int i = 0; i < `RX_SIG_BYTES; i++) begin
            send_byte(sig_field[8*i +: 8]);
        end
        for (int i = 0; i < n_data; i++) begin
            send_byte(frame_mem[i]);
        end
    endtask

    task automatic wait_for_strobe(input logic want_fcs, input string what);
        logic seen;
        int   n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < TIMEOUT_CYCLES) begin
            @(posedge clock);
            seen = want_fcs ? fcs_stb : header_stb;
            n++;
            #DRIVE_DELAY;
        end
        if (!seen) begin
            u_check.note_error($sformatf("timeout: %s never arrived", what));
        end
    endtask

    task automatic play_frame(input  rx_frame_pkg::legacy_sig_t s,
                              input  int                        n_data,
                              output logic                      fcs_due);
        rx_frame_pkg::rx_status_e  status;
        rx_frame_pkg::pkt_header_t header;
        logic                      fcs_good;
        predict(s, status, header, fcs_good);
        fcs_due = (status == rx_frame_pkg::E_OK);
        u_check.expect_frame(header, status, fcs_good);
        u_check.expect_idle(1'b0);
        // header strobe shows up while data bytes are still going in
        fork
            send_frame(s, n_data);
            wait_for_strobe(1'b0, "header strobe");
        join
    endtask

    task automatic finish_test(input int n_hdr, input int n_fcs);
        u_check.expect_idle(1'b1);
        idle_cycles(10);
        u_check.end_test(n_hdr, n_fcs);
    endtask

    task automatic run_test(input string name, input rx_frame_pkg::legacy_sig_t s,
                            input int n_data);
        logic fcs_due;
        u_check.begin_test(name);
        play_frame(s, n_data, fcs_due);
        if (fcs_due) begin
            wait_for_strobe(1'b1, "FCS strobe");
        end
        finish_test(1, fcs_due ? 1 : 0);
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        int   n;
        logic fcs_due;
        seed        = 32'h1b00;
        frame_start = 1'b0;
        byte_data   = 8'h00;
        byte_stb    = 1'b0;
        n           = 0;
        while (equalizer_reset !== 1'b0 && n < TIMEOUT_CYCLES) begin
            @(posedge clock);
            n++;
        end
        if (equalizer_reset !== 1'b0) begin
            u_check.note_error("reset was never released");
        end
        #DRIVE_DELAY;

        u_check.begin_test("idle after reset");
        idle_cycles(8);
        u_check.end_test(0, 0);

        // 6 Mb/s, 20 payload bytes plus FCS
        build_payload(20);
        good_sig = make_sig(4'b1011, 12'd24, 1'b0, 6'd0, 1'b0);
        run_test("good frame", good_sig, 24);
        frame_mem[7] = frame_mem[7] ^ 8'h5a;
        run_test("corrupted payload byte", good_sig, 24);

        build_payload(12);
        run_test("bad parity", make_sig(4'b1011, 12'd16, 1'b0, 6'd0, 1'b1), 16);
        run_test("reserved bit set", make_sig(4'b1011, 12'd16, 1'b1, 6'd0, 1'b0), 16);
        run_test("nonzero tail", make_sig(4'b1011, 12'd16, 1'b0, 6'h21, 1'b0), 16);
        run_test("rate bit 3 clear", make_sig(4'b0101, 12'd16, 1'b0, 6'd0, 1'b0), 16);
        run_test("tail and rate faults", make_sig(4'b0101, 12'd16, 1'b0, 6'h03, 1'b0), 16);
        run_test("rsvd, tail and rate faults", make_sig(4'b0101, 12'd16, 1'b1, 6'h03, 1'b0), 16);
        run_test("parity among several faults", make_sig(4'b0101, 12'd16, 1'b1, 6'h03, 1'b1), 16);

        // second preamble cuts the first frame after five data bytes
        u_check.begin_test("restart in mid-frame");
        play_frame(make_sig(4'b1011, 12'd16, 1'b0, 6'd0, 1'b0), 5, fcs_due);
        build_payload(26);
        play_frame(make_sig(4'b1101, 12'd30, 1'b0, 6'd0, 1'b0), 30, fcs_due);
        wait_for_strobe(1'b1, "FCS strobe");
        finish_test(2, 1);

        build_payload(40);
        run_test("long frame", make_sig(4'b1111, 12'd44, 1'b0, 6'd0, 1'b0), 44);

        u_check.print_totals();
        if (u_check.error_total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/rx_frame_checker.sv
`default_nettype none

module rx_frame_checker (
    input logic                      clock,
    input logic                      equalizer_reset,
    input logic                      demod_is_ongoing_i,
    input rx_frame_pkg::pkt_header_t pkt_header_i,
    input logic                      pkt_header_valid_strobe_i,
    input logic [15:0]               byte_count_i,
    input logic                      fcs_out_strobe_i,
    input logic                      fcs_ok_i,
    input rx_frame_pkg::rx_status_e  status_code_i
);
    timeunit 1ns;
    timeprecision 1ps;

    rx_frame_pkg::pkt_header_t exp_header;
    rx_frame_pkg::rx_status_e  exp_hdr_status;
    rx_frame_pkg::rx_status_e  exp_fcs_status;
    logic                      exp_fcs_ok;
    logic                      exp_fcs_due;
    logic                      idle_expected;
    string                     test_name;
    int                        test_errors;
    int                        hdr_seen;
    int                        fcs_seen;
    int                        pass_count;
    int                        fail_count;
    int                        error_total;

    initial begin
        exp_header     = '0;
        exp_hdr_status = rx_frame_pkg::E_OK;
        exp_fcs_status = rx_frame_pkg::E_OK;
        exp_fcs_ok     = 1'b0;
        exp_fcs_due    = 1'b0;
        idle_expected  = 1'b1;
        test_name      = "none";
        test_errors    = 0;
        hdr_seen       = 0;
        fcs_seen       = 0;
        pass_count     = 0;
        fail_count     = 0;
        error_total    = 0;
    end

    //////////////////////////////////////////////////
    // error bookkeeping
    //////////////////////////////////////////////////

    task automatic note_error(input string msg);
        $display("%s", msg);
        test_errors++;
        error_total++;
    endtask

    task automatic compare(input string sig_name, input logic [31:0] got,
                           input logic [31:0] want);
        if (got !== want) begin
            note_error($sformatf("error: %s got %h expected %h", sig_name, got, want));
        end
    endtask

    //////////////////////////////////////////////////
    // test control, called from the testbench top
    //////////////////////////////////////////////////

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        hdr_seen    = 0;
        fcs_seen    = 0;
    endtask

    task automatic expect_frame(input rx_frame_pkg::pkt_header_t header,
                                input rx_frame_pkg::rx_status_e  status,
                                input logic                      fcs_good);
        exp_header     = header;
        exp_hdr_status = status;
        exp_fcs_ok     = fcs_good;
        // only an accepted header leads to a data phase
        exp_fcs_due    = (status == rx_frame_pkg::E_OK);
        exp_fcs_status = fcs_good ? rx_frame_pkg::E_OK : rx_frame_pkg::E_WRONG_FCS;
    endtask

    task automatic expect_idle(input logic idle);
        idle_expected = idle;
    endtask

    task automatic end_test(input int hdr_want, input int fcs_want);
        if (hdr_seen != hdr_want) begin
            note_error($sformatf("saw %0d header strobes where %0d were due",
                                 hdr_seen, hdr_want));
        end
        if (fcs_seen != fcs_want) begin
            note_error($sformatf("saw %0d FCS strobes where %0d were due",
                                 fcs_seen, fcs_want));
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("test '%s': ok", test_name);
        end else begin
            fail_count++;
            $display("test '%s': fail with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic print_totals();
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    endtask

    //////////////////////////////////////////////////
    // monitor
    //////////////////////////////////////////////////

    always @(posedge clock) begin
        if (!equalizer_reset) begin
            if (pkt_header_valid_strobe_i) begin
                hdr_seen++;
                compare("pkt_header_o", 32'(pkt_header_i), 32'(exp_header));
                compare("status_code_o", 32'(status_code_i), 32'(exp_hdr_status));
                // an accepted header keeps the frame going
                if (exp_header.valid) begin
                    compare("demod_is_ongoing_o", 32'(demod_is_ongoing_i), 32'd1);
                end
            end
            if (fcs_out_strobe_i) begin
                fcs_seen++;
                if (!exp_fcs_due) begin
                    note_error("FCS strobe arrived after a rejected header");
                end else begin
                    compare("fcs_ok_o", 32'(fcs_ok_i), 32'(exp_fcs_ok));
                    compare("status_code_o", 32'(status_code_i), 32'(exp_fcs_status));
                    compare("byte_count_o", 32'(byte_count_i), 32'(exp_header.len));
                    compare("demod_is_ongoing_o", 32'(demod_is_ongoing_i), 32'd1);
                end
            end
            // nothing may move while no frame is on the air
            if (idle_expected && (demod_is_ongoing_i || pkt_header_valid_strobe_i ||
                                  fcs_out_strobe_i || fcs_ok_i)) begin
                note_error($sformatf("DUT busy between frames: demod %b header %b fcs %b ok %b",
                                     demod_is_ongoing_i, pkt_header_valid_strobe_i,
                                     fcs_out_strobe_i, fcs_ok_i));
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic equalizer_reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // release lands just after an edge, like the rest of the stimulus
    initial begin
        equalizer_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        equalizer_reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: design/rx_frame_top.sv
`default_nettype none

module rx_frame_top (
    input  logic                      clock,
    input  logic                      equalizer_reset,
    input  logic                      frame_start_i,
    input  logic [7:0]                byte_i,
    input  logic                      byte_stb_i,
    output logic                      demod_is_ongoing_o,
    output rx_frame_pkg::pkt_header_t pkt_header_o,
    output logic                      pkt_header_valid_strobe_o,
    output logic [15:0]               byte_count_o,
    output logic                      fcs_out_strobe_o,
    output logic                      fcs_ok_o,
    output rx_frame_pkg::rx_status_e  status_code_o
);

    rx_frame_pkg::sig_report_t sig_report;
    logic                      sig_stb;
    logic                      fcs_clear;
    logic [7:0]                fcs_byte;
    logic                      fcs_byte_stb;
    logic                      fcs_good;

    //////////////////////////////////////////////////
    // SIGNAL field input side
    //////////////////////////////////////////////////

    sig_field_parser u_parser (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .frame_start_i   (frame_start_i),
        .byte_i          (byte_i),
        .byte_stb_i      (byte_stb_i),
        .sig_report_o    (sig_report),
        .sig_stb_o       (sig_stb)
    );

    //////////////////////////////////////////////////
    // packet control and FCS
    //////////////////////////////////////////////////

    frame_sequencer u_sequencer (
        .clock                     (clock),
        .equalizer_reset           (equalizer_reset),
        .frame_start_i             (frame_start_i),
        .byte_i                    (byte_i),
        .byte_stb_i                (byte_stb_i),
        .sig_report_i              (sig_report),
        .sig_stb_i                 (sig_stb),
        .fcs_good_i                (fcs_good),
        .fcs_clear_o               (fcs_clear),
        .fcs_byte_o                (fcs_byte),
        .fcs_byte_stb_o            (fcs_byte_stb),
        .demod_is_ongoing_o        (demod_is_ongoing_o),
        .pkt_header_o              (pkt_header_o),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe_o),
        .byte_count_o              (byte_count_o),
        .fcs_out_strobe_o          (fcs_out_strobe_o),
        .fcs_ok_o                  (fcs_ok_o),
        .status_code_o             (status_code_o)
    );

    fcs_checker u_fcs (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .clear_i         (fcs_clear),
        .byte_i          (fcs_byte),
        .byte_stb_i      (fcs_byte_stb),
        .fcs_good_o      (fcs_good)
    );

endmodule

`default_nettype wire

// File: design/frame_sequencer.sv
`default_nettype none

module frame_sequencer (
    input  logic                      clock,
    input  logic                      equalizer_reset,
    input  logic                      frame_start_i,
    input  logic [7:0]                byte_i,
    input  logic                      byte_stb_i,
    input  rx_frame_pkg::sig_report_t sig_report_i,
    input  logic                      sig_stb_i,
    input  logic                      fcs_good_i,
    output logic                      fcs_clear_o,
    output logic [7:0]                fcs_byte_o,
    output logic                      fcs_byte_stb_o,
    output logic                      demod_is_ongoing_o,
    output rx_frame_pkg::pkt_header_t pkt_header_o,
    output logic                      pkt_header_valid_strobe_o,
    output logic [15:0]               byte_count_o,
    output logic                      fcs_out_strobe_o,
    output logic                      fcs_ok_o,
    output rx_frame_pkg::rx_status_e  status_code_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_SIG,
        S_DATA,
        S_FCS_REPORT,
        S_DONE
    } state_e;

    state_e      state_q;
    logic        sig_ok;
    logic        start_data;
    logic        accept_byte;
    logic [15:0] target_len;
    logic [15:0] base_count;
    logic [15:0] count_next;

    //////////////////////////////////////////////////
    // data byte acceptance
    //////////////////////////////////////////////////

    assign sig_ok     = (sig_report_i.status == rx_frame_pkg::E_OK);
    assign start_data = (state_q == S_WAIT_SIG) && sig_stb_i && sig_ok && !frame_start_i;

    // the first data byte may arrive in the same cycle as the report
    assign target_len = start_data ? 16'(sig_report_i.sig.len) : 16'(pkt_header_o.len);
    assign base_count = start_data ? 16'd0 : byte_count_o;

    assign accept_byte = byte_stb_i && !frame_start_i &&
                         (start_data || (state_q == S_DATA)) &&
                         (base_count < target_len);
    assign count_next  = base_count + 16'(accept_byte);

    // checker sees bytes in the same cycle so the verdict is ready one cycle later
    assign fcs_clear_o    = start_data;
    assign fcs_byte_o     = byte_i;
    assign fcs_byte_stb_o = accept_byte;

    //////////////////////////////////////////////////
    // packet FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            state_q                   <= S_IDLE;
            demod_is_ongoing_o        <= 1'b0;
            pkt_header_o              <= '0;
            pkt_header_valid_strobe_o <= 1'b0;
            byte_count_o              <= 16'd0;
            fcs_out_strobe_o          <= 1'b0;
            fcs_ok_o                  <= 1'b0;
            status_code_o             <= rx_frame_pkg::E_OK;
        end else begin
            pkt_header_valid_strobe_o <= 1'b0;
            fcs_out_strobe_o          <= 1'b0;

            if (frame_start_i) begin
                // whatever was in flight is dropped
                state_q            <= S_WAIT_SIG;
                demod_is_ongoing_o <= 1'b1;
                byte_count_o       <= 16'd0;
                fcs_ok_o           <= 1'b0;
            end else begin
                case (state_q)
                    S_WAIT_SIG: begin
                        if (sig_stb_i) begin
                            pkt_header_valid_strobe_o <= 1'b1;
                            pkt_header_o.rate         <= sig_report_i.sig.rate;
                            pkt_header_o.len          <= sig_report_i.sig.len;
                            pkt_header_o.valid        <= sig_ok;
                            status_code_o             <= sig_report_i.status;
                            if (sig_ok) begin
                                byte_count_o <= count_next;
                                if (count_next == target_len) begin
                                    state_q <= S_FCS_REPORT;
                                end else begin
                                    state_q <= S_DATA;
                                end
                            end else begin
                                demod_is_ongoing_o <= 1'b0;
                                state_q            <= S_IDLE;
                            end
                        end
                    end

                    S_DATA: begin
                        byte_count_o <= count_next;
                        if (count_next == target_len) begin
                            state_q <= S_FCS_REPORT;
                        end
                    end

                    S_FCS_REPORT: begin
                        fcs_out_strobe_o <= 1'b1;
                        fcs_ok_o         <= fcs_good_i;
                        if (fcs_good_i) begin
                            status_code_o <= rx_frame_pkg::E_OK;
                        end else begin
                            status_code_o <= rx_frame_pkg::E_WRONG_FCS;
                        end
                        state_q <= S_DONE;
                    end

                    S_DONE: begin
                        // count stays visible through the FCS strobe
                        demod_is_ongoing_o <= 1'b0;
                        fcs_ok_o           <= 1'b0;
                        byte_count_o       <= 16'd0;
                        state_q            <= S_IDLE;
                    end

                    default: begin
                        state_q <= S_IDLE;
                    end
                endcase
            end
        end
    end

    a_fcs_strobe_pulse: assert property (
        @(posedge clock) disable iff (equalizer_reset)
        fcs_out_strobe_o |=> !fcs_out_strobe_o
    );

    // counting stops at the header length
    a_count_in_range: assert property (
        @(posedge clock) disable iff (equalizer_reset)
        (state_q == S_DATA) |-> (byte_count_o <= 16'(pkt_header_o.len))
    );

endmodule

`default_nettype wire

// File: design/fcs_checker.sv
`default_nettype none

`include "rx_frame_macros.svh"

module fcs_checker (
    input  logic       clock,
    input  logic       equalizer_reset,
    input  logic       clear_i,
    input  logic [7:0] byte_i,
    input  logic       byte_stb_i,
    output logic       fcs_good_o
);

    localparam logic [31:0] CRC_POLY   = 32'h04C1_1DB7;
    localparam logic [31:0] CRC_PRESET = 32'hFFFF_FFFF;

    logic [31:0] crc_q;
    logic [31:0] crc_base;
    logic [31:0] crc_next;
    logic [7:0]  byte_rev;

    // one byte through the MSB-first register, bit 7 first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input logic [7:0]  data);
        logic [31:0] crc;
        logic        feedback;
        crc = crc_in;
        for (int i = 7; i >= 0; i--) begin
            feedback = crc[31] ^ data[i];
            crc = {crc[30:0], 1'b0};
            if (feedback) begin
                crc = crc ^ CRC_POLY;
            end
        end
        return crc;
    endfunction

    // 802.11 sends each byte LSB first
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            byte_rev[i] = byte_i[7-i];
        end
    end

    // a byte arriving with clear starts from the preset
    assign crc_base = clear_i ? CRC_PRESET : crc_q;
    assign crc_next = crc32_byte(crc_base, byte_rev);

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            crc_q <= CRC_PRESET;
        end else if (byte_stb_i) begin
            crc_q <= crc_next;
        end else if (clear_i) begin
            crc_q <= CRC_PRESET;
        end
    end

    // payload plus its own FCS leaves the fixed residue
    assign fcs_good_o = (crc_q == `RX_FCS_RESIDUE);

endmodule

`default_nettype wire

// File: design/sig_field_parser.sv
`default_nettype none

`include "rx_frame_macros.svh"

module sig_field_parser (
    input  logic                      clock,
    input  logic                      equalizer_reset,
    input  logic                      frame_start_i,
    input  logic [7:0]                byte_i,
    input  logic                      byte_stb_i,
    output rx_frame_pkg::sig_report_t sig_report_o,
    output logic                      sig_stb_o
);

    logic                      collecting_q;
    logic [1:0]                byte_idx_q;
    rx_frame_pkg::legacy_sig_t sig_shift_q;
    rx_frame_pkg::legacy_sig_t sig_next;
    rx_frame_pkg::rx_status_e  status_next;
    logic                      take_byte;
    logic                      last_byte;

    // new bytes enter from the top, so the first one ends up in bits 7:0
    assign sig_next  = {byte_i, sig_shift_q[`RX_SIG_BITS-1:8]};
    assign take_byte = collecting_q && byte_stb_i && !frame_start_i;
    assign last_byte = take_byte && (byte_idx_q == 2'(`RX_SIG_BYTES - 1));

    //////////////////////////////////////////////////
    // field checks, first failure wins
    //////////////////////////////////////////////////

    always_comb begin
        if (^{sig_next.parity, sig_next.len, sig_next.rsvd, sig_next.rate}) begin
            status_next = rx_frame_pkg::E_PARITY_FAIL;
        end else if (sig_next.rsvd) begin
            status_next = rx_frame_pkg::E_WRONG_RSVD;
        end else if (|sig_next.tail) begin
            status_next = rx_frame_pkg::E_WRONG_TAIL;
        end else if (!sig_next.rate[`RX_RATE_BITS-1]) begin
            // legacy rates all have the top rate bit set
            status_next = rx_frame_pkg::E_UNSUPPORTED_RATE;
        end else begin
            status_next = rx_frame_pkg::E_OK;
        end
    end

    //////////////////////////////////////////////////
    // byte collection
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            collecting_q <= 1'b0;
            byte_idx_q   <= 2'd0;
            sig_stb_o    <= 1'b0;
        end else begin
            sig_stb_o <= last_byte;
            if (frame_start_i) begin
                // a fresh preamble restarts collection at byte 0
                collecting_q <= 1'b1;
                byte_idx_q   <= 2'd0;
            end else if (take_byte) begin
                byte_idx_q <= byte_idx_q + 2'd1;
                if (last_byte) begin
                    collecting_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take_byte) begin
            sig_shift_q <= sig_next;
        end
        if (last_byte) begin
            sig_report_o.sig    <= sig_next;
            sig_report_o.status <= status_next;
        end
    end

    // one report per frame
    a_sig_stb_single: assert property (
        @(posedge clock) disable iff (equalizer_reset)
        sig_stb_o |=> !sig_stb_o
    );

endmodule

`default_nettype wire

// File: design/rx_frame_pkg.sv
`default_nettype none

`include "rx_frame_macros.svh"

package rx_frame_pkg;

    //////////////////////////////////////////////////
    // status codes
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        E_OK               = 3'd0,
        E_PARITY_FAIL      = 3'd1,
        E_WRONG_RSVD       = 3'd2,
        E_WRONG_TAIL       = 3'd3,
        E_UNSUPPORTED_RATE = 3'd4,
        E_WRONG_FCS        = 3'd5
    } rx_status_e;

    //////////////////////////////////////////////////
    // header formats
    //////////////////////////////////////////////////

    // declared high to low, so rate sits in bits 3:0 and tail in 23:18
    typedef struct packed {
        logic [`RX_TAIL_BITS-1:0] tail;
        logic                     parity;
        logic [`RX_LEN_BITS-1:0]  len;
        logic                     rsvd;
        logic [`RX_RATE_BITS-1:0] rate;
    } legacy_sig_t;

    // parsed field plus its verdict
    typedef struct packed {
        rx_status_e  status;
        legacy_sig_t sig;
    } sig_report_t;

    // what goes out with the header strobe
    typedef struct packed {
        logic                     valid;
        logic [`RX_RATE_BITS-1:0] rate;
        logic [`RX_LEN_BITS-1:0]  len;
    } pkt_header_t;

endpackage

`default_nettype wire

// File: design/rx_frame_macros.svh
`ifndef RX_FRAME_MACROS_SVH
`define RX_FRAME_MACROS_SVH

//////////////////////////////////////////////////
// legacy SIGNAL field layout
//////////////////////////////////////////////////

// SIGNAL arrives as three decoded bytes, first byte in the low bits
`define RX_SIG_BYTES 3
`define RX_SIG_BITS 24

// field widths inside SIGNAL
`define RX_RATE_BITS 4
`define RX_LEN_BITS 12
`define RX_TAIL_BITS 6

//////////////////////////////////////////////////
// frame check sequence
//////////////////////////////////////////////////

// CRC register value once the FCS bytes themselves have been run through
// the MSB-first register with bit-reversed input bytes
`define RX_FCS_RESIDUE 32'hC704_DD7B

`endif
